/* source/proc_pkg.sv */
/*
 * constants shared by the XOR copy engine and its register port
 * all transfers are full 32-bit words, INCR bursts, AXI ID zero
 */
`default_nettype none

package proc_pkg;

	// ==================================================
	// bus widths
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int APB_ADDR_BITS = 8;
	localparam int ID_WIDTH = 2;

	// word count register, 1 to 255 words per job
	localparam int LEN_BITS = 8;
	localparam logic [LEN_BITS-1:0] MAX_BURST = 16;

	// fifo sizing, count must hold the full depth
	localparam int FIFO_CNT_BITS = 6;
	localparam logic [FIFO_CNT_BITS-1:0] FIFO_DEPTH = 32;

	// ==================================================
	// register offsets
	localparam logic [APB_ADDR_BITS-1:0] REG_CTRL = 8'h00;
	localparam logic [APB_ADDR_BITS-1:0] REG_STATUS = 8'h04;
	localparam logic [APB_ADDR_BITS-1:0] REG_SRC = 8'h08;
	localparam logic [APB_ADDR_BITS-1:0] REG_DST = 8'h0C;
	localparam logic [APB_ADDR_BITS-1:0] REG_LEN = 8'h10;
	localparam logic [APB_ADDR_BITS-1:0] REG_KEY = 8'h14;

	// fixed AXI encodings, 4 byte beats
	localparam logic [2:0] AXI_SIZE_WORD = 3'b010;
	localparam logic [1:0] AXI_BURST_INCR = 2'b01;

endpackage

`default_nettype wire

/* source/word_fifo.sv */
/*
 * synchronous word FIFO with show-ahead output
 * depth must be a power of two, push when full and pop when empty are dropped
 */
`timescale 1ns/10ps
`default_nettype none

module word_fifo (
	input  logic clk,
	input  logic reset,
	input  logic push,
	input  logic [proc_pkg::DATA_WIDTH-1:0] wdata,
	input  logic pop,
	output logic [proc_pkg::DATA_WIDTH-1:0] rdata,
	output logic [proc_pkg::FIFO_CNT_BITS-1:0] count
);

	logic [proc_pkg::DATA_WIDTH-1:0] mem [0:proc_pkg::FIFO_DEPTH-1];
	// pointers one bit narrower than the count, wrap at depth
	logic [proc_pkg::FIFO_CNT_BITS-2:0] wr_ptr;
	logic [proc_pkg::FIFO_CNT_BITS-2:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign do_push = push && count != proc_pkg::FIFO_DEPTH;
	assign do_pop = pop && count != '0;
	assign rdata = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// simultaneous push and pop leaves count alone
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/apb_reg_slave.sv */
/*
 * APB register file, zero wait states, no PSTRB
 * address, length and key writes are dropped while busy
 */
`timescale 1ns/10ps
`default_nettype none

module apb_reg_slave (
	input  logic clk,
	input  logic reset,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [proc_pkg::APB_ADDR_BITS-1:0] paddr,
	input  logic [31:0] pwdata,
	input  logic job_done,
	input  logic resp_error,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic start,
	output logic [proc_pkg::ADDR_WIDTH-1:0] src_addr,
	output logic [proc_pkg::ADDR_WIDTH-1:0] dst_addr,
	output logic [proc_pkg::LEN_BITS-1:0] len,
	output logic [proc_pkg::DATA_WIDTH-1:0] key,
	output logic busy,
	output logic intr
);

	logic access;
	logic wr_en;
	logic mapped;
	logic irq_en;
	logic done;
	logic error;

	// access phase only
	assign access = psel & penable;
	assign wr_en = access & pwrite;
	assign pready = 1'b1;
	assign pslverr = access & ~mapped;
	assign intr = done & irq_en;

	// ==================================================
	// read mux and offset decode
	always_comb begin
		mapped = 1'b1;
		prdata = '0;
		case (paddr)
			// start bit always reads zero
			proc_pkg::REG_CTRL: prdata = {30'd0, irq_en, 1'b0};
			proc_pkg::REG_STATUS: prdata = {29'd0, error, done, busy};
			proc_pkg::REG_SRC: prdata = src_addr;
			proc_pkg::REG_DST: prdata = dst_addr;
			proc_pkg::REG_LEN: prdata = 32'(len);
			proc_pkg::REG_KEY: prdata = key;
			default: mapped = 1'b0;
		endcase
	end

	// ==================================================
	// control and status bits
	always_ff @(posedge clk) begin
		if (reset) begin
			start <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			error <= 1'b0;
			irq_en <= 1'b0;
		end else begin
			start <= 1'b0;
			if (wr_en && paddr == proc_pkg::REG_CTRL) begin
				irq_en <= pwdata[1];
				// start ignored while a job runs
				if (pwdata[0] && !busy) begin
					start <= 1'b1;
					busy <= 1'b1;
				end
			end
			// write one to clear
			if (wr_en && paddr == proc_pkg::REG_STATUS) begin
				if (pwdata[1])
					done <= 1'b0;
				if (pwdata[2])
					error <= 1'b0;
			end
			// set wins over a clear in the same cycle
			if (job_done) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
			if (resp_error)
				error <= 1'b1;
		end
	end

	// job parameters, frozen during a job
	always_ff @(posedge clk) begin
		if (wr_en && !busy) begin
			case (paddr)
				proc_pkg::REG_SRC: src_addr <= pwdata;
				proc_pkg::REG_DST: dst_addr <= pwdata;
				proc_pkg::REG_LEN: len <= pwdata[proc_pkg::LEN_BITS-1:0];
				proc_pkg::REG_KEY: key <= pwdata;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/axi_read_master.sv */
/*
 * AXI read burst engine, one burst in flight
 * fifo space is reserved before AR, so RREADY stays high while active
 * a burst must not cross a 4 KB boundary, source buffers are laid out accordingly
 */
`timescale 1ns/10ps
`default_nettype none

module axi_read_master (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic [proc_pkg::ADDR_WIDTH-1:0] src_addr,
	input  logic [proc_pkg::LEN_BITS-1:0] len,
	input  logic [proc_pkg::FIFO_CNT_BITS-1:0] fifo_count,
	input  logic arready,
	input  logic [proc_pkg::DATA_WIDTH-1:0] rdata,
	input  logic rvalid,
	input  logic rlast,
	output logic [proc_pkg::ADDR_WIDTH-1:0] araddr,
	output logic [7:0] arlen,
	output logic arvalid,
	output logic rready,
	output logic push,
	output logic [proc_pkg::DATA_WIDTH-1:0] push_data
);

	logic active;
	logic in_flight;
	logic issue;
	logic [proc_pkg::ADDR_WIDTH-1:0] next_addr;
	logic [proc_pkg::ADDR_WIDTH-1:0] burst_bytes;
	logic [proc_pkg::LEN_BITS-1:0] remain;
	logic [proc_pkg::LEN_BITS-1:0] burst_words;
	logic [proc_pkg::FIFO_CNT_BITS-1:0] free_words;

	// next burst is the smaller of max burst and words left
	assign burst_words = (remain > proc_pkg::MAX_BURST) ? proc_pkg::MAX_BURST : remain;
	assign burst_bytes = {{(proc_pkg::ADDR_WIDTH - proc_pkg::LEN_BITS - 2){1'b0}},
		burst_words, 2'b00};
	assign free_words = proc_pkg::FIFO_DEPTH - fifo_count;
	assign issue = active && !in_flight && remain != '0 && free_words >= burst_words;

	// every beat goes straight into the fifo
	assign rready = active;
	assign push = rvalid & rready;
	assign push_data = rdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			in_flight <= 1'b0;
			arvalid <= 1'b0;
		end else begin
			if (start)
				active <= 1'b1;
			else if (active && !in_flight && remain == '0)
				active <= 1'b0;
			// AR held until accepted
			if (issue) begin
				arvalid <= 1'b1;
				in_flight <= 1'b1;
			end else if (arvalid && arready) begin
				arvalid <= 1'b0;
			end
			if (push && rlast)
				in_flight <= 1'b0;
		end
	end

	// address and count step once per burst
	always_ff @(posedge clk) begin
		if (start) begin
			next_addr <= src_addr;
			remain <= len;
		end else if (issue) begin
			araddr <= next_addr;
			arlen <= burst_words - 8'd1;
			next_addr <= next_addr + burst_bytes;
			remain <= remain - burst_words;
		end
	end

endmodule

`default_nettype wire

/* source/axi_write_master.sv */
/*
 * AXI write burst engine, AW then W beats then B, one burst at a time
 * a burst waits until the fifo holds all of its words
 */
`timescale 1ns/10ps
`default_nettype none

module axi_write_master (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic [proc_pkg::ADDR_WIDTH-1:0] dst_addr,
	input  logic [proc_pkg::LEN_BITS-1:0] len,
	input  logic [proc_pkg::DATA_WIDTH-1:0] key,
	input  logic [proc_pkg::FIFO_CNT_BITS-1:0] fifo_count,
	input  logic [proc_pkg::DATA_WIDTH-1:0] fifo_data,
	input  logic awready,
	input  logic wready,
	input  logic [1:0] bresp,
	input  logic bvalid,
	output logic [proc_pkg::ADDR_WIDTH-1:0] awaddr,
	output logic [7:0] awlen,
	output logic awvalid,
	output logic [proc_pkg::DATA_WIDTH-1:0] wdata,
	output logic wvalid,
	output logic wlast,
	output logic bready,
	output logic pop,
	output logic job_done,
	output logic resp_error
);

	typedef enum logic [2:0] {ST_IDLE, ST_WAIT, ST_ADDR, ST_DATA, ST_RESP} state_t;

	state_t state;
	logic err_acc;
	logic aw_load;
	logic [proc_pkg::ADDR_WIDTH-1:0] next_addr;
	logic [proc_pkg::ADDR_WIDTH-1:0] burst_bytes;
	logic [proc_pkg::LEN_BITS-1:0] remain;
	logic [proc_pkg::LEN_BITS-1:0] burst_words;
	logic [proc_pkg::LEN_BITS-1:0] beats_left;

	assign burst_words = (remain > proc_pkg::MAX_BURST) ? proc_pkg::MAX_BURST : remain;
	assign burst_bytes = {{(proc_pkg::ADDR_WIDTH - proc_pkg::LEN_BITS - 2){1'b0}},
		burst_words, 2'b00};
	assign aw_load = state == ST_WAIT && remain != '0 && fifo_count >= burst_words;

	// ==================================================
	// channel outputs decoded from state
	assign awvalid = state == ST_ADDR;
	assign wvalid = state == ST_DATA;
	assign wlast = wvalid && beats_left == 8'd1;
	// show-ahead word, stable until popped
	assign wdata = fifo_data ^ key;
	assign pop = wvalid & wready;
	assign bready = state == ST_RESP;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			err_acc <= 1'b0;
			job_done <= 1'b0;
			resp_error <= 1'b0;
		end else begin
			job_done <= 1'b0;
			resp_error <= 1'b0;
			case (state)
				ST_IDLE: if (start) begin
					state <= ST_WAIT;
					err_acc <= 1'b0;
				end
				// zero length job ends here
				ST_WAIT: if (remain == '0) begin
					job_done <= 1'b1;
					resp_error <= err_acc;
					state <= ST_IDLE;
				end else if (aw_load) begin
					state <= ST_ADDR;
				end
				ST_ADDR: if (awready)
					state <= ST_DATA;
				ST_DATA: if (wready && wlast)
					state <= ST_RESP;
				ST_RESP: if (bvalid) begin
					// any non OKAY response is an error
					if (bresp != 2'b00)
						err_acc <= 1'b1;
					if (remain == '0) begin
						job_done <= 1'b1;
						resp_error <= err_acc | (bresp != 2'b00);
						state <= ST_IDLE;
					end else begin
						state <= ST_WAIT;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// burst payload, loaded when the fifo has a full burst
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && start) begin
			next_addr <= dst_addr;
			remain <= len;
		end else if (aw_load) begin
			awaddr <= next_addr;
			awlen <= burst_words - 8'd1;
			beats_left <= burst_words;
			next_addr <= next_addr + burst_bytes;
			remain <= remain - burst_words;
		end else if (pop) begin
			beats_left <= beats_left - 8'd1;
		end
	end

endmodule

`default_nettype wire

/* source/processor_axi_wrapper.sv */
/*
 * XOR copy processor, APB registers in front, AXI4 master behind
 * IDs are zero, lock, cache, QoS and region are not driven
 */
`timescale 1ns/10ps
`default_nettype none

module processor_axi_wrapper (
	input  logic clk,
	input  logic reset,
	// apb slave
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [proc_pkg::APB_ADDR_BITS-1:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic busy,
	output logic intr,
	// read address and data
	output logic [proc_pkg::ID_WIDTH-1:0] arid,
	output logic [proc_pkg::ADDR_WIDTH-1:0] araddr,
	output logic [7:0] arlen,
	output logic [2:0] arsize,
	output logic [1:0] arburst,
	output logic arvalid,
	input  logic arready,
	input  logic [proc_pkg::DATA_WIDTH-1:0] rdata,
	input  logic [1:0] rresp,
	input  logic rvalid,
	input  logic rlast,
	output logic rready,
	// write address, data and response
	output logic [proc_pkg::ID_WIDTH-1:0] awid,
	output logic [proc_pkg::ADDR_WIDTH-1:0] awaddr,
	output logic [7:0] awlen,
	output logic [2:0] awsize,
	output logic [1:0] awburst,
	output logic awvalid,
	input  logic awready,
	output logic [proc_pkg::DATA_WIDTH-1:0] wdata,
	output logic [proc_pkg::DATA_WIDTH/8-1:0] wstrb,
	output logic wvalid,
	output logic wlast,
	input  logic wready,
	input  logic [1:0] bresp,
	input  logic bvalid,
	output logic bready
);

	logic start;
	logic [proc_pkg::ADDR_WIDTH-1:0] src_addr;
	logic [proc_pkg::ADDR_WIDTH-1:0] dst_addr;
	logic [proc_pkg::LEN_BITS-1:0] len;
	logic [proc_pkg::DATA_WIDTH-1:0] key;
	logic job_done;
	logic wr_resp_error;
	logic read_error;
	logic push;
	logic pop;
	logic [proc_pkg::DATA_WIDTH-1:0] push_data;
	logic [proc_pkg::DATA_WIDTH-1:0] fifo_data;
	logic [proc_pkg::FIFO_CNT_BITS-1:0] fifo_count;

	// ==================================================
	// fixed AXI fields
	assign arid = '0;
	assign awid = '0;
	assign arsize = proc_pkg::AXI_SIZE_WORD;
	assign awsize = proc_pkg::AXI_SIZE_WORD;
	assign arburst = proc_pkg::AXI_BURST_INCR;
	assign awburst = proc_pkg::AXI_BURST_INCR;
	assign wstrb = '1;

	// a bad read beat also flags the job
	assign read_error = rvalid & rready & (rresp != 2'b00);

	apb_reg_slave u_regs (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.job_done(job_done), .resp_error(wr_resp_error | read_error),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.start(start), .src_addr(src_addr), .dst_addr(dst_addr),
		.len(len), .key(key), .busy(busy), .intr(intr)
	);

	axi_read_master u_rd (
		.clk(clk), .reset(reset), .start(start),
		.src_addr(src_addr), .len(len), .fifo_count(fifo_count),
		.arready(arready), .rdata(rdata), .rvalid(rvalid), .rlast(rlast),
		.araddr(araddr), .arlen(arlen), .arvalid(arvalid),
		.rready(rready), .push(push), .push_data(push_data)
	);

	word_fifo u_fifo (
		.clk(clk), .reset(reset),
		.push(push), .wdata(push_data), .pop(pop),
		.rdata(fifo_data), .count(fifo_count)
	);

	axi_write_master u_wr (
		.clk(clk), .reset(reset), .start(start),
		.dst_addr(dst_addr), .len(len), .key(key),
		.fifo_count(fifo_count), .fifo_data(fifo_data),
		.awready(awready), .wready(wready), .bresp(bresp), .bvalid(bvalid),
		.awaddr(awaddr), .awlen(awlen), .awvalid(awvalid),
		.wdata(wdata), .wvalid(wvalid), .wlast(wlast), .bready(bready),
		.pop(pop), .job_done(job_done), .resp_error(wr_resp_error)
	);

endmodule

`default_nettype wire

/* sim/axi_mem_model.sv */
/*
 * AXI4 slave memory for the testbench, 1024 words, one burst per direction
 * writes at word 0x380 and above are dropped and answered with SLVERR
 * ready stalls come from the testbench, fill port loads the array
 */
`timescale 1ns/10ps
`default_nettype none

module axi_mem_model (
	input  logic clk,
	input  logic reset,
	input  logic ar_stall,
	input  logic aw_stall,
	input  logic w_stall,
	input  logic fill_en,
	input  logic [9:0] fill_idx,
	input  logic [31:0] fill_data,
	input  logic [31:0] araddr,
	input  logic [7:0] arlen,
	input  logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	output logic rlast,
	input  logic rready,
	input  logic [31:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [31:0] wdata,
	input  logic wvalid,
	input  logic wlast,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready
);

	localparam int MEM_WORDS = 1024;
	localparam logic [9:0] ERR_BASE = 10'h380;

	logic [31:0] mem [0:MEM_WORDS-1];
	logic rd_active;
	logic [9:0] rd_idx;
	logic [7:0] rd_left;
	logic wr_active;
	logic [9:0] wr_idx;
	logic wr_err;

	// one burst at a time per channel
	assign arready = !rd_active && !ar_stall;
	assign awready = !wr_active && !bvalid && !aw_stall;
	assign wready = wr_active && !w_stall;
	assign rvalid = rd_active;
	assign rdata = mem[rd_idx];
	assign rlast = rd_active && rd_left == 8'd0;
	assign rresp = 2'b00;

	always_ff @(posedge clk) begin
		if (fill_en)
			mem[fill_idx] <= fill_data;
		if (reset) begin
			rd_active <= 1'b0;
			wr_active <= 1'b0;
			bvalid <= 1'b0;
			bresp <= 2'b00;
		end else begin
			// read side
			if (arvalid && arready) begin
				rd_active <= 1'b1;
				rd_idx <= araddr[11:2];
				rd_left <= arlen;
			end else if (rvalid && rready) begin
				if (rd_left == 8'd0) begin
					rd_active <= 1'b0;
				end else begin
					rd_idx <= rd_idx + 10'd1;
					rd_left <= rd_left - 8'd1;
				end
			end
			// write side, error region swallows data
			if (awvalid && awready) begin
				wr_active <= 1'b1;
				wr_idx <= awaddr[11:2];
				wr_err <= 1'b0;
			end else if (wvalid && wready) begin
				if (wr_idx >= ERR_BASE)
					wr_err <= 1'b1;
				else
					mem[wr_idx] <= wdata;
				wr_idx <= wr_idx + 10'd1;
				if (wlast) begin
					wr_active <= 1'b0;
					bvalid <= 1'b1;
					bresp <= (wr_err || wr_idx >= ERR_BASE) ? 2'b10 : 2'b00;
				end
			end
			if (bvalid && bready)
				bvalid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* sim/processor_axi_wrapper_chk.sv */
/*
 * protocol checks bound into the top level
 * failures are counted in assert_fails for the testbench summary
 */
`timescale 1ns/10ps
`default_nettype none

module processor_axi_wrapper_chk (
	input  logic clk,
	input  logic reset,
	input  logic [1:0] arid,
	input  logic [2:0] arsize,
	input  logic [1:0] arburst,
	input  logic arvalid,
	input  logic arready,
	input  logic [31:0] araddr,
	input  logic [7:0] arlen,
	input  logic rvalid,
	input  logic rready,
	input  logic rlast,
	input  logic [1:0] awid,
	input  logic [2:0] awsize,
	input  logic [1:0] awburst,
	input  logic awvalid,
	input  logic awready,
	input  logic [31:0] awaddr,
	input  logic [7:0] awlen,
	input  logic wvalid,
	input  logic wready,
	input  logic wlast,
	input  logic [31:0] wdata,
	input  logic [3:0] wstrb
);

	int assert_fails = 0;
	logic [7:0] rbeat;
	logic [7:0] wbeat;

	// beat counters within the current burst
	always_ff @(posedge clk) begin
		if (reset) begin
			rbeat <= 8'd0;
			wbeat <= 8'd0;
		end else begin
			if (rvalid && rready)
				rbeat <= rlast ? 8'd0 : rbeat + 8'd1;
			if (wvalid && wready)
				wbeat <= wlast ? 8'd0 : wbeat + 8'd1;
		end
	end

	// ==================================================
	// valid held with stable payload until ready
	ar_hold: assert property (@(posedge clk) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
		else begin
			$error("ARVALID dropped or AR payload changed before ARREADY");
			assert_fails = assert_fails + 1;
		end

	aw_hold: assert property (@(posedge clk) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
		else begin
			$error("AWVALID dropped or AW payload changed before AWREADY");
			assert_fails = assert_fails + 1;
		end

	w_hold: assert property (@(posedge clk) disable iff (reset)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
		else begin
			$error("WVALID dropped or W payload changed before WREADY");
			assert_fails = assert_fails + 1;
		end

	// last flags on beat len+1
	w_last: assert property (@(posedge clk) disable iff (reset)
		wvalid && wready |-> wlast == (wbeat == awlen))
		else begin
			$error("WLAST not on beat AWLEN+1");
			assert_fails = assert_fails + 1;
		end

	r_last: assert property (@(posedge clk) disable iff (reset)
		rvalid && rready |-> rlast == (rbeat == arlen))
		else begin
			$error("RLAST not on beat ARLEN+1");
			assert_fails = assert_fails + 1;
		end

	// fixed fields, ID zero, 4 byte INCR bursts, full strobes
	ar_fixed: assert property (@(posedge clk) disable iff (reset)
		arvalid |-> arid == 2'd0 && arsize == 3'b010 && arburst == 2'b01)
		else begin
			$error("AR ID, size or burst type is not ID 0, 4 bytes, INCR");
			assert_fails = assert_fails + 1;
		end

	aw_fixed: assert property (@(posedge clk) disable iff (reset)
		awvalid |-> awid == 2'd0 && awsize == 3'b010 && awburst == 2'b01)
		else begin
			$error("AW ID, size or burst type is not ID 0, 4 bytes, INCR");
			assert_fails = assert_fails + 1;
		end

	w_strobe: assert property (@(posedge clk) disable iff (reset)
		wvalid |-> wstrb == 4'hf)
		else begin
			$error("WSTRB not all ones on a write beat");
			assert_fails = assert_fails + 1;
		end

endmodule

`default_nettype wire

/* sim/tb_top.sv */
/*
 * runs the jobs listed in sim/processor_testdata.txt against the AXI memory model
 * expected words come from a local copy of the model memory
 * jobs must not overlap source and destination, dst stays inside 1024 words
 */
`timescale 1ns/10ps
`default_nettype none

module tb_top;

	localparam int MEM_WORDS = 1024;
	localparam int MAX_TESTS = 16;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [proc_pkg::APB_ADDR_BITS-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic busy;
	logic intr;
	logic [proc_pkg::ID_WIDTH-1:0] arid;
	logic [31:0] araddr;
	logic [7:0] arlen;
	logic [2:0] arsize;
	logic [1:0] arburst;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rlast;
	logic rready;
	logic [proc_pkg::ID_WIDTH-1:0] awid;
	logic [31:0] awaddr;
	logic [7:0] awlen;
	logic [2:0] awsize;
	logic [1:0] awburst;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wlast;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic ar_stall;
	logic aw_stall;
	logic w_stall;
	logic fill_en;
	logic [9:0] fill_idx;
	logic [31:0] fill_data;
	logic stall_on;
	logic [15:0] lfsr;
	int wd_limit = 0;

	// local copy of the model memory, and the jobs from the data file
	logic [31:0] mem_copy [0:MEM_WORDS-1];
	string t_name [MAX_TESTS];
	logic [31:0] t_src [MAX_TESTS];
	logic [31:0] t_dst [MAX_TESTS];
	logic [31:0] t_len [MAX_TESTS];
	logic [31:0] t_key [MAX_TESTS];
	logic [31:0] t_err [MAX_TESTS];

	processor_axi_wrapper DUT (.*);
	axi_mem_model mem_model (.*);
	bind processor_axi_wrapper processor_axi_wrapper_chk u_chk (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ==================================================
	// random bits, 16 bit Fibonacci LFSR
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			bits = {bits[30:0], lfsr[0]};
		end
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("mismatch %s expected %h actual %h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	// ==================================================
	// APB, setup then access, sampled mid cycle
	task automatic bus_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
		output logic [31:0] rd_data, output logic slv_err);
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = data;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		rd_data = prdata;
		slv_err = pslverr;
		// zero wait states, ready in every access phase
		check("pready in access phase", 32'd1, 32'(pready));
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic err;
		bus_access(1'b1, addr, data, rd, err);
	endtask

	task automatic expect_reg(input string name, input logic [7:0] addr,
		input logic [31:0] expected);
		logic [31:0] rd;
		logic err;
		bus_access(1'b0, addr, 32'd0, rd, err);
		check(name, expected, rd);
		check({name, " pslverr"}, 32'd0, 32'(err));
	endtask

	// ==================================================
	// one job, programmed, disturbed while busy, then checked
	task automatic run_job(input int t);
		string nm;
		logic irq;
		logic [31:0] key;
		logic [31:0] expw;
		int si;
		int di;
		int n;
		nm = t_name[t];
		irq = t[0];
		key = t_key[t];
		si = int'(t_src[t] >> 2);
		di = int'(t_dst[t] >> 2);
		n = int'(t_len[t]);
		write_reg(proc_pkg::REG_SRC, t_src[t]);
		write_reg(proc_pkg::REG_DST, t_dst[t]);
		write_reg(proc_pkg::REG_LEN, t_len[t]);
		write_reg(proc_pkg::REG_KEY, key);
		expect_reg({nm, " src"}, proc_pkg::REG_SRC, t_src[t]);
		expect_reg({nm, " dst"}, proc_pkg::REG_DST, t_dst[t]);
		expect_reg({nm, " len"}, proc_pkg::REG_LEN, t_len[t]);
		expect_reg({nm, " key"}, proc_pkg::REG_KEY, key);
		write_reg(proc_pkg::REG_CTRL, {30'd0, irq, 1'b1});
		check({nm, " busy after start"}, 32'd1, 32'(busy));
		// second start and new key, both dropped while busy
		write_reg(proc_pkg::REG_CTRL, {30'd0, irq, 1'b1});
		write_reg(proc_pkg::REG_KEY, ~key);
		expect_reg({nm, " ctrl"}, proc_pkg::REG_CTRL, {30'd0, irq, 1'b0});
		while (busy === 1'b1) begin
			@(posedge clk);
			#1;
		end
		check({nm, " intr"}, 32'(irq), 32'(intr));
		expect_reg({nm, " status"}, proc_pkg::REG_STATUS, {29'd0, t_err[t][0], 2'b10});
		expect_reg({nm, " key kept"}, proc_pkg::REG_KEY, key);
		// error jobs leave memory alone
		for (int i = 0; i < n; i++) begin
			expw = t_err[t][0] ? mem_copy[di+i] : mem_copy[si+i] ^ key;
			check({nm, " dst word"}, expw, mem_model.mem[di+i]);
			mem_copy[di+i] = expw;
		end
		if (di > 0)
			check({nm, " word below dst"}, mem_copy[di-1], mem_model.mem[di-1]);
		if (di + n < MEM_WORDS)
			check({nm, " word above dst"}, mem_copy[di+n], mem_model.mem[di+n]);
		write_reg(proc_pkg::REG_STATUS, 32'h6);
		check({nm, " intr cleared"}, 32'd0, 32'(intr));
		expect_reg({nm, " status cleared"}, proc_pkg::REG_STATUS, 32'd0);
	endtask

	// watchdog, armed once the job list is known
	initial begin
		wait (wd_limit != 0);
		repeat (wd_limit) @(posedge clk);
		$display("timeout: jobs did not finish within %0d cycles", wd_limit);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	// ready stalls on AR, AW and W
	initial begin
		logic [31:0] bits;
		wait (stall_on);
		forever begin
			@(posedge clk);
			#1;
			take_bits(3, bits);
			ar_stall = bits[0];
			aw_stall = bits[1];
			w_stall = bits[2];
		end
	end

	initial begin
		int fd;
		int count;
		int words;
		string line;
		string nm;
		logic [31:0] s;
		logic [31:0] d;
		logic [31:0] l;
		logic [31:0] k;
		logic [31:0] e;
		logic [31:0] word;
		logic [31:0] rd;
		logic err;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		ar_stall = 1'b0;
		aw_stall = 1'b0;
		w_stall = 1'b0;
		fill_en = 1'b0;
		fill_idx = '0;
		fill_data = '0;
		stall_on = 1'b0;
		lfsr = 16'd5330;
		count = 0;
		words = 0;
		fd = $fopen("sim/processor_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open sim/processor_testdata.txt");
			$display("TEST FAILED");
			$fatal(1, "no test data");
		end
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) > 0 && line.substr(0, 0) != "#") begin
				if ($sscanf(line, "%s %h %h %h %h %h", nm, s, d, l, k, e) == 6
					&& count < MAX_TESTS) begin
					t_name[count] = nm;
					t_src[count] = s;
					t_dst[count] = d;
					t_len[count] = l;
					t_key[count] = k;
					t_err[count] = e;
					words = words + int'(l);
					count = count + 1;
				end
			end
		end
		$fclose(fd);
		wd_limit = words * 400 + MEM_WORDS + 5000;

		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		// fill model and local copy with the same random words
		for (int i = 0; i < MEM_WORDS; i++) begin
			@(posedge clk);
			#1;
			take_bits(32, word);
			fill_en = 1'b1;
			fill_idx = 10'(i);
			fill_data = word;
			mem_copy[i] = word;
		end
		@(posedge clk);
		#1;
		fill_en = 1'b0;
		stall_on = 1'b1;

		bus_access(1'b0, 8'h18, 32'd0, rd, err);
		check("unmapped offset pslverr", 32'd1, 32'(err));
		for (int t = 0; t < count; t++)
			run_job(t);

		if (DUT.u_chk.assert_fails != 0) begin
			$display("%0d protocol assertions failed", DUT.u_chk.assert_fails);
			$display("TEST FAILED");
			$fatal(1, "assertion failures");
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* sim/processor_testdata.txt */
# name src dst len key err, all hex except name
# err is 1 when the destination lies in the model error region (0xe00 and up)
len1 00000000 00000400 01 a5a5a5a5 0
len16 00000010 00000440 10 0f0f1234 0
len17 00000080 00000500 11 deadbeef 0
len255 00000400 00000800 ff 13579bdf 0
len48_zero_key 00000100 00000600 30 00000000 0
err_dst 00000200 00000e00 08 55aa55aa 1
below_err 00000300 00000dc0 10 ffffffff 0
after_err 000003c0 00000c00 05 01020304 0

/* processor_axi_wrapper.f */
source/proc_pkg.sv
source/word_fifo.sv
source/apb_reg_slave.sv
source/axi_read_master.sv
source/axi_write_master.sv
source/processor_axi_wrapper.sv
sim/axi_mem_model.sv
sim/processor_axi_wrapper_chk.sv
sim/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, pass only if the log holds the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f processor_axi_wrapper.f

./obj_dir/Vtb_top +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST OK" sim.log; then
	exit 0
fi
exit 1
